// File: verilog/display_pkg.sv
////////////////////////////////////////////////////////////
// display package: 720p geometry, sync timing, square setup
// and TMDS control symbols shared by the bounce design
////////////////////////////////////////////////////////////

package display_pkg;

    localparam int CORDW = 12;          // screen coordinate width in bits

    // horizontal timing in pixels
    localparam int H_RES  = 1280;       // active pixels per line
    localparam int H_FP   = 110;        // front porch
    localparam int H_SYNC = 40;         // sync pulse
    localparam int H_BP   = 220;        // back porch
    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 1650

    // vertical timing in lines
    localparam int V_RES  = 720;        // active lines per frame
    localparam int V_FP   = 5;          // front porch
    localparam int V_SYNC = 5;          // sync pulse
    localparam int V_BP   = 20;         // back porch
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 750

    // square 1, drawn in red
    localparam int Q1_SIZE  = 200;      // side length in pixels
    localparam int Q1_SPEED = 4;        // pixels per frame
    localparam int Q1_X0    = 100;      // start column
    localparam int Q1_Y0    = 50;       // start line

    // square 2, drawn in green
    localparam int Q2_SIZE  = 300;
    localparam int Q2_SPEED = 2;
    localparam int Q2_X0    = 500;
    localparam int Q2_Y0    = 200;

    // square 3, drawn in blue
    localparam int Q3_SIZE  = 400;
    localparam int Q3_SPEED = 2;
    localparam int Q3_X0    = 800;
    localparam int Q3_Y0    = 300;

    // TMDS control symbols, bit 9 down to bit 0, indexed by {c1,c0}
    localparam logic [9:0] CTRL_00 = 10'b1101010100;
    localparam logic [9:0] CTRL_01 = 10'b0010101011;
    localparam logic [9:0] CTRL_10 = 10'b0101010100;
    localparam logic [9:0] CTRL_11 = 10'b1010101011;

    // running disparity stays well inside +-16 for a valid encoder
    localparam int DISPW = 5;           // signed disparity counter width

endpackage

// File: verilog/display_timing.sv
////////////////////////////////////////////////////////////
// display timing: 1280x720 raster counters with registered
// sync, data enable and a one-cycle frame animate pulse
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module display_timing (
    input  logic                            clk_pix,    // pixel clock
    input  logic                            arst_n,     // async reset, active low
    output logic [display_pkg::CORDW-1:0]   sx,         // current column
    output logic [display_pkg::CORDW-1:0]   sy,         // current line
    output logic                            hsync,      // active high
    output logic                            vsync,      // active high
    output logic                            de,         // active video
    output logic                            animate     // start of vertical blank
);

    import display_pkg::*;

    logic [CORDW-1:0] sx_next;  // position the counters move to
    logic [CORDW-1:0] sy_next;

    // raster order, wrap at end of line and end of frame
    always_comb begin
        sx_next = sx + 1'b1;
        sy_next = sy;
        if (sx == CORDW'(H_TOTAL - 1)) begin
            sx_next = '0;
            sy_next = (sy == CORDW'(V_TOTAL - 1)) ? '0 : sy + 1'b1;
        end
    end

    // decode flags from the next position so they line up with sx/sy
    // the first pixel after reset therefore shows with de low
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx      <= '0;
            sy      <= '0;
            hsync   <= 1'b0;
            vsync   <= 1'b0;
            de      <= 1'b0;
            animate <= 1'b0;
        end else begin
            sx      <= sx_next;
            sy      <= sy_next;
            hsync   <= (int'(sx_next) >= H_RES + H_FP)
                    && (int'(sx_next) <  H_RES + H_FP + H_SYNC);  // after front porch
            vsync   <= (int'(sy_next) >= V_RES + V_FP)
                    && (int'(sy_next) <  V_RES + V_FP + V_SYNC);
            de      <= (int'(sx_next) < H_RES) && (int'(sy_next) < V_RES);
            animate <= (int'(sy_next) == V_RES) && (sx_next == '0);  // once per frame
        end
    end

endmodule

// File: verilog/square_motion.sv
////////////////////////////////////////////////////////////
// square motion: position and direction of one bouncing
// square, stepped once per frame on the animate pulse
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module square_motion #(
    parameter int SIZE  = 200,  // side length in pixels
    parameter int SPEED = 2,    // pixels moved per frame
    parameter int X0    = 0,    // start column
    parameter int Y0    = 0     // start line
) (
    input  logic                            clk_pix,
    input  logic                            arst_n,
    input  logic                            animate,    // one pulse per frame
    output logic [display_pkg::CORDW-1:0]   qx,         // left edge
    output logic [display_pkg::CORDW-1:0]   qy          // top edge
);

    import display_pkg::*;

    logic             dx;       // 1 moves left
    logic             dy;       // 1 moves up
    logic [CORDW:0]   x_next;   // {direction, position}
    logic [CORDW:0]   y_next;

    // one axis of the bounce rule, returns {dir, pos}
    function automatic logic [CORDW:0] bounce(
        input logic [CORDW-1:0] pos,
        input logic             dir,
        input int               limit
    );
        logic [CORDW-1:0] step;
        step = CORDW'(SPEED);
        if (int'(pos) >= limit - (SIZE + SPEED)) begin
            return {1'b1, pos - step};                      // far edge, turn back
        end else if (int'(pos) < SPEED) begin
            return {1'b0, pos + step};                      // near edge, turn forward
        end else begin
            return {dir, dir ? pos - step : pos + step};    // keep going
        end
    endfunction

    always_comb begin
        x_next = bounce(qx, dx, H_RES);
        y_next = bounce(qy, dy, V_RES);
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            qx <= CORDW'(X0);
            qy <= CORDW'(Y0);
            dx <= 1'b0;             // start right
            dy <= 1'b0;             // and down
        end else if (animate) begin
            {dx, qx} <= x_next;     // visible the cycle after animate
            {dy, qy} <= y_next;
        end
    end

endmodule

// File: verilog/square_painter.sv
////////////////////////////////////////////////////////////
// square painter: tests the pixel against three squares and
// registers colour with its sync and enable
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module square_painter (
    input  logic                            clk_pix,
    input  logic                            arst_n,
    input  logic [display_pkg::CORDW-1:0]   sx,
    input  logic [display_pkg::CORDW-1:0]   sy,
    input  logic [display_pkg::CORDW-1:0]   q1x,
    input  logic [display_pkg::CORDW-1:0]   q1y,
    input  logic [display_pkg::CORDW-1:0]   q2x,
    input  logic [display_pkg::CORDW-1:0]   q2y,
    input  logic [display_pkg::CORDW-1:0]   q3x,
    input  logic [display_pkg::CORDW-1:0]   q3y,
    input  logic                            hsync,
    input  logic                            vsync,
    input  logic                            de,
    output logic [7:0]                      pix_red,
    output logic [7:0]                      pix_green,
    output logic [7:0]                      pix_blue,
    output logic                            pix_hsync,
    output logic                            pix_vsync,
    output logic                            pix_de
);

    import display_pkg::*;

    logic q1_draw;  // square 1 covers this pixel
    logic q2_draw;
    logic q3_draw;

    // half-open box test, origin at the top-left corner
    function automatic logic covers(
        input logic [CORDW-1:0] px,
        input logic [CORDW-1:0] py,
        input logic [CORDW-1:0] qx,
        input logic [CORDW-1:0] qy,
        input int               size
    );
        return (px >= qx) && (int'(px) < int'(qx) + size)
            && (py >= qy) && (int'(py) < int'(qy) + size);
    endfunction

    always_comb begin
        q1_draw = covers(sx, sy, q1x, q1y, Q1_SIZE);
        q2_draw = covers(sx, sy, q2x, q2y, Q2_SIZE);
        q3_draw = covers(sx, sy, q3x, q3y, Q3_SIZE);
    end

    // one cycle of delay, sync and enable follow the colour
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            pix_red   <= 8'h00;
            pix_green <= 8'h00;
            pix_blue  <= 8'h00;
            pix_hsync <= 1'b0;
            pix_vsync <= 1'b0;
            pix_de    <= 1'b0;
        end else begin
            pix_red   <= (de && q1_draw) ? 8'hFF : 8'h00;   // black in blanking
            pix_green <= (de && q2_draw) ? 8'hFF : 8'h00;
            pix_blue  <= (de && q3_draw) ? 8'hFF : 8'h00;
            pix_hsync <= hsync;
            pix_vsync <= vsync;
            pix_de    <= de;
        end
    end

endmodule

// File: verilog/tmds_link.sv
////////////////////////////////////////////////////////////
// TMDS link: 8b/10b DVI encoding of blue, green and red with
// running disparity, control symbols while blanking
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tmds_link (
    input  logic        clk_pix,
    input  logic        arst_n,
    input  logic [7:0]  pix_red,
    input  logic [7:0]  pix_green,
    input  logic [7:0]  pix_blue,
    input  logic        pix_hsync,
    input  logic        pix_vsync,
    input  logic        pix_de,
    output logic [9:0]  tmds_ch0,   // blue plus sync
    output logic [9:0]  tmds_ch1,   // green
    output logic [9:0]  tmds_ch2    // red
);

    import display_pkg::*;

    logic [7:0]              data [3];  // channel bytes
    logic [1:0]              ctrl [3];  // {c1,c0} per channel
    logic [DISPW+9:0]        enc  [3];  // {next disparity, symbol}
    logic [9:0]              sym  [3];  // registered symbols
    logic signed [DISPW-1:0] disp [3];  // running disparity, ones minus zeros

    // step 1: xor or xnor chain, whichever gives fewer transitions
    function automatic logic [8:0] transition_min(input logic [7:0] d);
        logic       use_xnor;
        logic [8:0] qm;
        use_xnor = ($countones(d) > 4) || ($countones(d) == 4 && !d[0]);
        qm[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            qm[i] = use_xnor ? ~(qm[i-1] ^ d[i]) : (qm[i-1] ^ d[i]);
        end
        qm[8] = ~use_xnor;          // tells the sink which chain was used
        return qm;
    endfunction

    // step 2: invert when it pulls the running disparity back to zero
    function automatic logic [DISPW+9:0] dc_balance(
        input logic [8:0]              qm,
        input logic signed [DISPW-1:0] cnt
    );
        int         n1;
        int         n0;
        int         cnt_new;
        logic [9:0] q_out;
        n1 = $countones(qm[7:0]);
        n0 = 8 - n1;
        if (cnt == 0 || n1 == n0) begin
            q_out   = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            cnt_new = qm[8] ? int'(cnt) + n1 - n0 : int'(cnt) + n0 - n1;
        end else if ((cnt > 0 && n1 > n0) || (cnt < 0 && n0 > n1)) begin
            q_out   = {1'b1, qm[8], ~qm[7:0]};  // inverted
            cnt_new = int'(cnt) + 2 * int'(qm[8]) + n0 - n1;
        end else begin
            q_out   = {1'b0, qm[8], qm[7:0]};
            cnt_new = int'(cnt) - 2 * int'(!qm[8]) + n1 - n0;
        end
        return {cnt_new[DISPW-1:0], q_out};
    endfunction

    always_comb begin
        data[0] = pix_blue;
        data[1] = pix_green;
        data[2] = pix_red;
        ctrl[0] = {pix_vsync, pix_hsync};   // only ch0 carries sync
        ctrl[1] = 2'b00;
        ctrl[2] = 2'b00;
        for (int i = 0; i < 3; i++) begin
            enc[i] = dc_balance(transition_min(data[i]), disp[i]);
        end
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 3; i++) begin
                sym[i]  <= CTRL_00;
                disp[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (pix_de) begin
                    {disp[i], sym[i]} <= enc[i];
                end else begin
                    disp[i] <= '0;          // balance restarts each blanking
                    case (ctrl[i])
                        2'b00:   sym[i] <= CTRL_00;
                        2'b01:   sym[i] <= CTRL_01;
                        2'b10:   sym[i] <= CTRL_10;
                        default: sym[i] <= CTRL_11;
                    endcase
                end
            end
        end
    end

    assign tmds_ch0 = sym[0];
    assign tmds_ch1 = sym[1];
    assign tmds_ch2 = sym[2];

endmodule

// File: verilog/bounce_top.sv
////////////////////////////////////////////////////////////
// bounce top: timing, three square movers, painter and TMDS
// encoder producing parallel DVI symbols
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bounce_top (
    input  logic        clk_pix,    // 74.25 MHz pixel clock
    input  logic        arst_n,     // async reset, active low
    output logic [9:0]  tmds_ch0,   // blue and sync symbols
    output logic [9:0]  tmds_ch1,   // green symbols
    output logic [9:0]  tmds_ch2    // red symbols
);

    import display_pkg::*;

    logic [CORDW-1:0] sx, sy;       // raster position
    logic             hsync, vsync, de, animate;
    logic [CORDW-1:0] q1x, q1y;     // square top-left corners
    logic [CORDW-1:0] q2x, q2y;
    logic [CORDW-1:0] q3x, q3y;
    logic [7:0]       pix_red, pix_green, pix_blue;
    logic             pix_hsync, pix_vsync, pix_de;

    display_timing u_timing (
        .clk_pix, .arst_n,
        .sx, .sy,
        .hsync, .vsync, .de,
        .animate
    );

    square_motion #(
        .SIZE(Q1_SIZE), .SPEED(Q1_SPEED), .X0(Q1_X0), .Y0(Q1_Y0)
    ) u_sq1 (
        .clk_pix, .arst_n, .animate,
        .qx(q1x), .qy(q1y)
    );

    square_motion #(
        .SIZE(Q2_SIZE), .SPEED(Q2_SPEED), .X0(Q2_X0), .Y0(Q2_Y0)
    ) u_sq2 (
        .clk_pix, .arst_n, .animate,
        .qx(q2x), .qy(q2y)
    );

    square_motion #(
        .SIZE(Q3_SIZE), .SPEED(Q3_SPEED), .X0(Q3_X0), .Y0(Q3_Y0)
    ) u_sq3 (
        .clk_pix, .arst_n, .animate,
        .qx(q3x), .qy(q3y)
    );

    square_painter u_painter (
        .clk_pix, .arst_n,
        .sx, .sy,
        .q1x, .q1y, .q2x, .q2y, .q3x, .q3y,
        .hsync, .vsync, .de,
        .pix_red, .pix_green, .pix_blue,
        .pix_hsync, .pix_vsync, .pix_de
    );

    tmds_link u_tmds (
        .clk_pix, .arst_n,
        .pix_red, .pix_green, .pix_blue,
        .pix_hsync, .pix_vsync, .pix_de,
        .tmds_ch0, .tmds_ch1, .tmds_ch2
    );

endmodule

// File: tb/bounce_props.sv
////////////////////////////////////////////////////////////
// TMDS link properties: control symbol legality in blanking
// and running disparity bounds, bound into tmds_link
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bounce_props (
    input logic                                 clk_pix,
    input logic                                 arst_n,
    input logic                                 pix_de,
    input logic [9:0]                           tmds_ch0,
    input logic [9:0]                           tmds_ch1,
    input logic [9:0]                           tmds_ch2,
    input logic signed [display_pkg::DISPW-1:0] disp0,      // blue channel disparity
    input logic signed [display_pkg::DISPW-1:0] disp1,      // green
    input logic signed [display_pkg::DISPW-1:0] disp2       // red
);

    import display_pkg::*;

    logic ctrl_ok;      // all three symbols are control codes
    logic disp_ok;      // all three counters inside +-10
    logic disp_zero;

    function automatic logic is_ctrl(input logic [9:0] s);
        return (s == CTRL_00) || (s == CTRL_01) || (s == CTRL_10) || (s == CTRL_11);
    endfunction

    assign ctrl_ok   = is_ctrl(tmds_ch0) && is_ctrl(tmds_ch1) && is_ctrl(tmds_ch2);
    assign disp_ok   = (disp0 >= -10) && (disp0 <= 10) && (disp1 >= -10) && (disp1 <= 10)
                    && (disp2 >= -10) && (disp2 <= 10);
    assign disp_zero = (disp0 == 0) && (disp1 == 0) && (disp2 == 0);

    // symbols registered from active pixels keep the balance bounded
    disp_bounded: assert property (@(posedge clk_pix) disable iff (!arst_n)
        pix_de |=> disp_ok)
        else $error("running disparity left the +-10 window");

    // blanking input gives control symbols one cycle later
    ctrl_legal: assert property (@(posedge clk_pix) disable iff (!arst_n)
        !pix_de |=> ctrl_ok)
        else $error("non-control symbol sent during blanking");

    disp_cleared: assert property (@(posedge clk_pix) disable iff (!arst_n)
        $fell(pix_de) |=> disp_zero)
        else $error("disparity not cleared after data enable fell");

endmodule

bind tmds_link bounce_props u_props (
    .clk_pix, .arst_n, .pix_de,
    .tmds_ch0, .tmds_ch1, .tmds_ch2,
    .disp0(disp[0]), .disp1(disp[1]), .disp2(disp[2])
);

// File: tb/bounce_tb.sv
////////////////////////////////////////////////////////////
// bounce testbench samples TMDS symbols at raster points and
// checks them against a square motion model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bounce_tb;

    import display_pkg::*;

    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;      // pixels per frame
    localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 100; // four frames plus slack
    localparam int LATENCY        = 2;                       // painter plus encoder

    logic       clk_pix;
    logic       arst_n;
    logic [9:0] tmds_ch0;
    logic [9:0] tmds_ch1;
    logic [9:0] tmds_ch2;

    int cycle;                  // posedges since reset release
    int timeout_count = 0;      // posedges since time zero

    // sample table where rgb is the expected {red,green,blue} coverage
    int         row_frame [$];
    int         row_x     [$];
    int         row_y     [$];
    logic [2:0] row_rgb   [$];
    string      row_name  [$];

    // model indexed by channel so 0 is square 3 (blue) and 2 is square 1 (red)
    int q_size  [3];
    int q_speed [3];
    int q_x     [3];
    int q_y     [3];
    int q_dx    [3];        // +1 right, -1 left
    int q_dy    [3];        // +1 down, -1 up
    int model_frame;

    bounce_top u_bounce_top (
        .clk_pix,
        .arst_n,
        .tmds_ch0,
        .tmds_ch1,
        .tmds_ch2
    );

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;  // 10 ns period
    end

    always @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    always @(posedge clk_pix) begin
        timeout_count <= timeout_count + 1;
        if (timeout_count >= TIMEOUT_CYCLES) begin
            fail_run("timeout: the run did not reach the last table row");
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string name, input int ch,
                                   input logic [9:0] exp, input logic [9:0] act);
        fail_run($sformatf("Mismatch %s ch%0d: expected %h, actual %h", name, ch, exp, act));
    endtask

    // DVI receiver side undoes the inversion and then the xor/xnor chain
    function automatic logic [7:0] decode_tmds(input logic [9:0] s);
        logic [7:0] d;
        logic [7:0] b;
        d = s[9] ? ~s[7:0] : s[7:0];
        b[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            b[i] = s[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
        end
        return b;
    endfunction

    function automatic logic [9:0] ctrl_symbol(input logic [1:0] c);   // c is {vsync,hsync}
        case (c)
            2'b00:   return CTRL_00;
            2'b01:   return CTRL_01;
            2'b10:   return CTRL_10;
            default: return CTRL_11;
        endcase
    endfunction

    function automatic logic inside_square(input int i, input int x, input int y);
        return (x >= q_x[i]) && (x < q_x[i] + q_size[i])
            && (y >= q_y[i]) && (y < q_y[i] + q_size[i]);
    endfunction

    // far edge turns back, near edge turns forward, else keep going
    task automatic bounce_axis(inout int pos, inout int dir,
                               input int size, input int speed, input int limit);
        if (pos >= limit - (size + speed)) begin
            dir = -1;
        end else if (pos < speed) begin
            dir = 1;
        end
        pos = pos + dir * speed;
    endtask

    task automatic advance_model();
        int p;
        int d;
        for (int i = 0; i < 3; i++) begin
            p = q_x[i];
            d = q_dx[i];
            bounce_axis(p, d, q_size[i], q_speed[i], H_RES);
            q_x[i]  = p;
            q_dx[i] = d;
            p = q_y[i];
            d = q_dy[i];
            bounce_axis(p, d, q_size[i], q_speed[i], V_RES);
            q_y[i]  = p;
            q_dy[i] = d;
        end
        model_frame++;
    endtask

    task automatic init_model();
        q_size      = '{Q3_SIZE, Q2_SIZE, Q1_SIZE};
        q_speed     = '{Q3_SPEED, Q2_SPEED, Q1_SPEED};
        q_x         = '{Q3_X0, Q2_X0, Q1_X0};
        q_y         = '{Q3_Y0, Q2_Y0, Q1_Y0};
        q_dx        = '{1, 1, 1};
        q_dy        = '{1, 1, 1};
        model_frame = 0;
    endtask

    task automatic add_row(input int f, input int x, input int y,
                           input logic [2:0] rgb, input string name);
        row_frame.push_back(f);
        row_x.push_back(x);
        row_y.push_back(y);
        row_rgb.push_back(rgb);
        row_name.push_back(name);
    endtask

    // rows in raster order at square edges and in blanking
    task automatic build_table();
        add_row(0,  100,  49, 3'b000, "f0_q1_above");
        add_row(0,   99,  50, 3'b000, "f0_q1_left_out");
        add_row(0,  100,  50, 3'b100, "f0_q1_corner_in");
        add_row(0,  300,  50, 3'b000, "f0_q1_right_out");
        add_row(0,  500, 200, 3'b010, "f0_q2_corner_in");
        add_row(0, 1400, 200, 3'b000, "f0_hsync");
        add_row(0,  799, 300, 3'b010, "f0_q2_right_in");
        add_row(0,  800, 300, 3'b001, "f0_q3_corner_in");
        add_row(0, 1199, 699, 3'b001, "f0_q3_far_in");
        add_row(0, 1200, 699, 3'b000, "f0_q3_right_out");
        add_row(0,   10, 725, 3'b000, "f0_vsync");
        add_row(0, 1400, 727, 3'b000, "f0_vsync_hsync");
        add_row(1,  103,  54, 3'b000, "f1_q1_left_out");
        add_row(1,  104,  54, 3'b100, "f1_q1_corner_in");
        add_row(1,  304, 253, 3'b000, "f1_q1_right_out");
        add_row(1,  802, 302, 3'b001, "f1_q3_corner_in");
        add_row(2,  108,  57, 3'b000, "f2_q1_above");
        add_row(2,  107,  58, 3'b000, "f2_q1_left_out");
        add_row(2,  108,  58, 3'b100, "f2_q1_corner_in");
        add_row(2,  504, 204, 3'b010, "f2_q2_corner_in");
        add_row(3,  111,  62, 3'b000, "f3_q1_left_out");
        add_row(3,  112,  62, 3'b100, "f3_q1_corner_in");
        add_row(3,  311, 261, 3'b100, "f3_q1_far_in");
        add_row(3,  312, 261, 3'b000, "f3_q1_right_out");
        add_row(3, 1205, 705, 3'b001, "f3_q3_far_in");
        add_row(3, 1206, 705, 3'b000, "f3_q3_right_out");
    endtask

    task automatic check_reset_symbols(input int n);
        string name;
        name = $sformatf("reset_ctrl_%0d", n);
        assert (tmds_ch0 == CTRL_00) else report_mismatch(name, 0, CTRL_00, tmds_ch0);
        assert (tmds_ch1 == CTRL_00) else report_mismatch(name, 1, CTRL_00, tmds_ch1);
        assert (tmds_ch2 == CTRL_00) else report_mismatch(name, 2, CTRL_00, tmds_ch2);
    endtask

    task automatic check_row(input int r);
        int         x;
        int         y;
        logic       de_exp;
        logic [1:0] sync_exp;       // {vsync,hsync}
        logic [2:0] rgb_model;
        logic [9:0] got [3];
        logic [9:0] sym_exp;
        logic [7:0] byte_exp;
        logic [7:0] byte_act;
        x      = row_x[r];
        y      = row_y[r];
        got[0] = tmds_ch0;
        got[1] = tmds_ch1;
        got[2] = tmds_ch2;
        de_exp      = (x < H_RES) && (y < V_RES);
        sync_exp[1] = (y >= V_RES + V_FP) && (y < V_RES + V_FP + V_SYNC);
        sync_exp[0] = (x >= H_RES + H_FP) && (x < H_RES + H_FP + H_SYNC);
        for (int i = 0; i < 3; i++) begin
            rgb_model[i] = de_exp && inside_square(i, x, y);
        end
        assert (rgb_model == row_rgb[r])
            else fail_run($sformatf("table row %s disagrees with the motion model", row_name[r]));
        for (int i = 0; i < 3; i++) begin
            if (de_exp) begin
                byte_exp = rgb_model[i] ? 8'hFF : 8'h00;
                byte_act = decode_tmds(got[i]);
                assert (byte_act == byte_exp)
                    else report_mismatch(row_name[r], i, {2'b00, byte_exp}, {2'b00, byte_act});
            end else begin
                sym_exp = (i == 0) ? ctrl_symbol(sync_exp) : CTRL_00;  // sync rides on ch0
                assert (got[i] == sym_exp)
                    else report_mismatch(row_name[r], i, sym_exp, got[i]);
            end
        end
    endtask

    initial begin
        int target;
        arst_n = 1'b0;
        build_table();
        init_model();
        repeat (10) @(negedge clk_pix);
        arst_n = 1'b1;                      // cycle is 0 on this falling edge
        for (int n = 0; n < 3; n++) begin   // reset values and then pixel 0 with de low
            check_reset_symbols(n);
            @(negedge clk_pix);
        end
        foreach (row_name[r]) begin
            target = row_frame[r] * FRAME_CYCLES + row_y[r] * H_TOTAL + row_x[r] + LATENCY;
            assert (target >= cycle)
                else fail_run($sformatf("table row %s is out of raster order", row_name[r]));
            while (cycle < target) begin
                @(negedge clk_pix);
            end
            while (model_frame < row_frame[r]) begin
                advance_model();
            end
            check_row(r);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: files.f
verilog/display_pkg.sv
verilog/display_timing.sv
verilog/square_motion.sv
verilog/square_painter.sv
verilog/tmds_link.sv
verilog/bounce_top.sv
tb/bounce_props.sv
tb/bounce_tb.sv

// File: Makefile
# Verilator flow for the bouncing squares DVI design

TOP := bounce_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
